// File: design/fifo_pkg.sv
package fifo_pkg;

   // default stream widths, bytes in and words out
   parameter int DEF_W_DATA_W = 8;
   parameter int DEF_R_DATA_W = 32;

   // address width in narrow units, 64 bytes of storage
   parameter int DEF_ADDR_W = 6;

   // words the read stage may hold or have in flight
   parameter int RD_SLOTS = 2;

   // wider of the two port widths
   function automatic int max_w(input int a, input int b);
      return (a > b) ? a : b;
   endfunction

   // narrower of the two port widths
   function automatic int min_w(input int a, input int b);
      return (a < b) ? a : b;
   endfunction

   // number of narrow lanes in one wide word
   function automatic int lane_cnt(input int a, input int b);
      return max_w(a, b) / min_w(a, b);
   endfunction

endpackage

// File: design/fifo_asym_converter.sv
`timescale 1ns/100ps

module fifo_asym_converter #(
   parameter int W_DATA_W = 8,
   parameter int R_DATA_W = 32,
   parameter int ADDR_W   = 6
) (
   input  logic clk_i,
   input  logic rst_n_i,

   input  logic w_en_i,
   input  logic [W_ADDR_W-1:0] w_addr_i,
   input  logic [W_DATA_W-1:0] w_data_i,

   input  logic r_en_i,
   input  logic [R_ADDR_W-1:0] r_addr_i,
   output logic [R_DATA_W-1:0] r_data_o,

   output logic [R-1:0] ram_w_en_o,
   output logic [MINADDR_W-1:0] ram_w_addr_o,
   output logic [MAXDATA_W-1:0] ram_w_data_o,
   output logic [R-1:0] ram_r_en_o,
   output logic [MINADDR_W-1:0] ram_r_addr_o,
   input  logic [MAXDATA_W-1:0] ram_r_data_i
);

   localparam int MAXDATA_W = fifo_pkg::max_w(W_DATA_W, R_DATA_W);
   localparam int MINDATA_W = fifo_pkg::min_w(W_DATA_W, R_DATA_W);
   localparam int R = fifo_pkg::lane_cnt(W_DATA_W, R_DATA_W);
   localparam int MINADDR_W = ADDR_W - $clog2(R);
   localparam int W_ADDR_W = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W;
   localparam int R_ADDR_W = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W;

   localparam int LANE_W = (R > 1) ? $clog2(R) : 1;
   localparam bit W_NARROW = (W_DATA_W < R_DATA_W);
   localparam bit R_NARROW = (R_DATA_W < W_DATA_W);

   logic [LANE_W-1:0] r_lane;
   logic [LANE_W-1:0] r_lane_q;

   // upper address bits select the RAM row on both sides
   assign ram_w_addr_o = w_addr_i[W_ADDR_W-1 -: MINADDR_W];
   assign ram_r_addr_o = r_addr_i[R_ADDR_W-1 -: MINADDR_W];

   // narrow write hits one lane, wide write hits all
   always_comb begin
      ram_w_en_o = '0;
      if (W_NARROW) begin
         ram_w_en_o[w_addr_i[LANE_W-1:0]] = w_en_i;
      end else begin
         ram_w_en_o = {R{w_en_i}};
      end
   end

   generate
      if (W_NARROW) begin : g_w_rep
         // same byte on every lane, enables pick the one that lands
         assign ram_w_data_o = {R{w_data_i}};
      end else begin : g_w_pass
         assign ram_w_data_o = w_data_i;
      end
   endgenerate

   // read lane from low address bits, zero when read side is wide
   assign r_lane = R_NARROW ? r_addr_i[LANE_W-1:0] : '0;

   always_comb begin
      ram_r_en_o = '0;
      if (R_NARROW) begin
         ram_r_en_o[r_lane] = r_en_i;
      end else begin
         ram_r_en_o = {R{r_en_i}};
      end
   end

   // lane of the access that is returning next cycle
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         r_lane_q <= '0;
      end else if (r_en_i) begin
         r_lane_q <= r_lane;
      end
   end

   // full word when read side is wide since r_lane_q stays 0
   assign r_data_o = ram_r_data_i[r_lane_q*MINDATA_W +: R_DATA_W];

endmodule

// File: design/fifo_sync.sv
`timescale 1ns/100ps

module fifo_sync #(
   parameter int W_DATA_W = 8,
   parameter int R_DATA_W = 32,
   parameter int ADDR_W   = 6
) (
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic clr_i,

   // write port
   input  logic w_en_i,
   input  logic [W_DATA_W-1:0] w_data_i,
   output logic w_full_o,

   // read port
   input  logic r_en_i,
   output logic [R_DATA_W-1:0] r_data_o,
   output logic r_empty_o,

   // RAM side
   output logic [R-1:0] ram_w_en_o,
   output logic [MINADDR_W-1:0] ram_w_addr_o,
   output logic [MAXDATA_W-1:0] ram_w_data_o,
   output logic [R-1:0] ram_r_en_o,
   output logic [MINADDR_W-1:0] ram_r_addr_o,
   input  logic [MAXDATA_W-1:0] ram_r_data_i,

   output logic [ADDR_W:0] level_o
);

   localparam int MAXDATA_W = fifo_pkg::max_w(W_DATA_W, R_DATA_W);
   localparam int MINDATA_W = fifo_pkg::min_w(W_DATA_W, R_DATA_W);
   localparam int R = MAXDATA_W / MINDATA_W;
   localparam int ADDR_W_DIFF = $clog2(R);
   localparam int MINADDR_W = ADDR_W - ADDR_W_DIFF;
   localparam int W_ADDR_W = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W;
   localparam int R_ADDR_W = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W;

   // level steps in narrow units
   localparam logic [ADDR_W:0] W_INCR = (W_DATA_W > R_DATA_W) ? (1 << ADDR_W_DIFF) : 1;
   localparam logic [ADDR_W:0] R_INCR = (R_DATA_W > W_DATA_W) ? (1 << ADDR_W_DIFF) : 1;
   localparam logic [ADDR_W:0] FIFO_SIZE = 1 << ADDR_W;

   logic w_en_int;
   logic r_en_int;
   logic [W_ADDR_W-1:0] w_addr;
   logic [R_ADDR_W-1:0] r_addr;
   logic [ADDR_W:0] level_q;
   logic [ADDR_W:0] level_nxt;

   // requests only take effect when the flags allow
   assign w_en_int = w_en_i & ~w_full_o;
   assign r_en_int = r_en_i & ~r_empty_o;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         w_addr <= '0;
      end else if (clr_i) begin
         w_addr <= '0;
      end else if (w_en_int) begin
         w_addr <= w_addr + 1'b1;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         r_addr <= '0;
      end else if (clr_i) begin
         r_addr <= '0;
      end else if (r_en_int) begin
         r_addr <= r_addr + 1'b1;
      end
   end

   always_comb begin
      level_nxt = level_q;
      if (w_en_int && r_en_int) begin
         level_nxt = level_q + W_INCR - R_INCR;
      end else if (w_en_int) begin
         level_nxt = level_q + W_INCR;
      end else if (r_en_int) begin
         level_nxt = level_q - R_INCR;
      end
   end

   // flags come from the next level so they move with it
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         level_q   <= '0;
         r_empty_o <= 1'b1;
         w_full_o  <= 1'b0;
      end else if (clr_i) begin
         level_q   <= '0;
         r_empty_o <= 1'b1;
         w_full_o  <= 1'b0;
      end else begin
         level_q   <= level_nxt;
         r_empty_o <= (level_nxt < R_INCR);
         w_full_o  <= (level_nxt > (FIFO_SIZE - W_INCR));
      end
   end

   assign level_o = level_q;

   fifo_asym_converter #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .ADDR_W  (ADDR_W)
   ) u_conv (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .w_en_i      (w_en_int),
      .w_addr_i    (w_addr),
      .w_data_i    (w_data_i),
      .r_en_i      (r_en_int),
      .r_addr_i    (r_addr),
      .r_data_o    (r_data_o),
      .ram_w_en_o  (ram_w_en_o),
      .ram_w_addr_o(ram_w_addr_o),
      .ram_w_data_o(ram_w_data_o),
      .ram_r_en_o  (ram_r_en_o),
      .ram_r_addr_o(ram_r_addr_o),
      .ram_r_data_i(ram_r_data_i)
   );

endmodule

// File: design/fifo_lane_ram.sv
`timescale 1ns/100ps

module fifo_lane_ram #(
   parameter int MINDATA_W = 8,
   parameter int R         = 4,
   parameter int MINADDR_W = 4
) (
   input  logic clk_i,

   input  logic [R-1:0] w_en_i,
   input  logic [MINADDR_W-1:0] w_addr_i,
   input  logic [R*MINDATA_W-1:0] w_data_i,

   input  logic [R-1:0] r_en_i,
   input  logic [MINADDR_W-1:0] r_addr_i,
   output logic [R*MINDATA_W-1:0] r_data_o
);

   localparam int DEPTH = 2 ** MINADDR_W;

   genvar i;
   generate
      for (i = 0; i < R; i++) begin : g_lane
         logic [MINDATA_W-1:0] mem [DEPTH];
         logic [MINDATA_W-1:0] rd_q;

         always_ff @(posedge clk_i) begin
            if (w_en_i[i]) begin
               mem[w_addr_i] <= w_data_i[i*MINDATA_W +: MINDATA_W];
            end
         end

         // one cycle read latency, lane output holds when not read
         always_ff @(posedge clk_i) begin
            if (r_en_i[i]) begin
               rd_q <= mem[r_addr_i];
            end
         end

         assign r_data_o[i*MINDATA_W +: MINDATA_W] = rd_q;
      end
   endgenerate

endmodule

// File: design/fifo_rd_stage.sv
`timescale 1ns/100ps

module fifo_rd_stage #(
   parameter int DATA_W = 32
) (
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic clr_i,

   // FIFO read side
   output logic r_en_o,
   input  logic r_empty_i,
   input  logic [DATA_W-1:0] r_data_i,

   // stream output
   output logic out_valid_o,
   output logic [DATA_W-1:0] out_data_o,
   input  logic out_ready_i
);

   localparam int CNT_W = $clog2(fifo_pkg::RD_SLOTS + 2);

   logic inflight_q;
   logic head_vld_q;
   logic tail_vld_q;
   logic [DATA_W-1:0] head_q;
   logic [DATA_W-1:0] tail_q;
   logic [CNT_W-1:0] used;
   logic push;
   logic pop;

   // held words plus the read still coming back from the RAM
   assign used = CNT_W'(head_vld_q) + CNT_W'(tail_vld_q) + CNT_W'(inflight_q);
   assign r_en_o = ~r_empty_i & (used < CNT_W'(fifo_pkg::RD_SLOTS));

   assign push = inflight_q;
   assign pop  = head_vld_q & out_ready_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         inflight_q <= 1'b0;
         head_vld_q <= 1'b0;
         tail_vld_q <= 1'b0;
      end else if (clr_i) begin
         inflight_q <= 1'b0;
         head_vld_q <= 1'b0;
         tail_vld_q <= 1'b0;
      end else begin
         inflight_q <= r_en_o;
         if (pop) begin
            head_vld_q <= tail_vld_q | push;
            tail_vld_q <= tail_vld_q & push;
         end else if (push) begin
            head_vld_q <= 1'b1;
            tail_vld_q <= head_vld_q;
         end
      end
   end

   // head refills from tail first so order is kept
   always_ff @(posedge clk_i) begin
      if (pop && tail_vld_q) begin
         head_q <= tail_q;
      end else if (push && (pop || !head_vld_q)) begin
         head_q <= r_data_i;
      end
      if (push && ((pop && tail_vld_q) || (!pop && head_vld_q))) begin
         tail_q <= r_data_i;
      end
   end

   assign out_valid_o = head_vld_q;
   assign out_data_o  = head_q;

endmodule

// File: design/fifo_top.sv
`timescale 1ns/100ps

module fifo_top #(
   parameter int W_DATA_W = fifo_pkg::DEF_W_DATA_W,
   parameter int R_DATA_W = fifo_pkg::DEF_R_DATA_W,
   parameter int ADDR_W   = fifo_pkg::DEF_ADDR_W
) (
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic clr_i,

   // byte stream in
   input  logic in_valid_i,
   input  logic [W_DATA_W-1:0] in_data_i,
   output logic in_ready_o,

   // word stream out
   output logic out_valid_o,
   output logic [R_DATA_W-1:0] out_data_o,
   input  logic out_ready_i,

   output logic [ADDR_W:0] level_o
);

   localparam int MAXDATA_W = fifo_pkg::max_w(W_DATA_W, R_DATA_W);
   localparam int MINDATA_W = fifo_pkg::min_w(W_DATA_W, R_DATA_W);
   localparam int R = MAXDATA_W / MINDATA_W;
   localparam int MINADDR_W = ADDR_W - $clog2(R);

   logic w_full;
   logic r_en;
   logic r_empty;
   logic [R_DATA_W-1:0] r_data;
   logic [R-1:0] ram_w_en;
   logic [MINADDR_W-1:0] ram_w_addr;
   logic [MAXDATA_W-1:0] ram_w_data;
   logic [R-1:0] ram_r_en;
   logic [MINADDR_W-1:0] ram_r_addr;
   logic [MAXDATA_W-1:0] ram_r_data;

   assign in_ready_o = ~w_full;

   fifo_sync #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .ADDR_W  (ADDR_W)
   ) u_fifo (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .clr_i       (clr_i),
      .w_en_i      (in_valid_i),
      .w_data_i    (in_data_i),
      .w_full_o    (w_full),
      .r_en_i      (r_en),
      .r_data_o    (r_data),
      .r_empty_o   (r_empty),
      .ram_w_en_o  (ram_w_en),
      .ram_w_addr_o(ram_w_addr),
      .ram_w_data_o(ram_w_data),
      .ram_r_en_o  (ram_r_en),
      .ram_r_addr_o(ram_r_addr),
      .ram_r_data_i(ram_r_data),
      .level_o     (level_o)
   );

   fifo_lane_ram #(
      .MINDATA_W(MINDATA_W),
      .R        (R),
      .MINADDR_W(MINADDR_W)
   ) u_ram (
      .clk_i   (clk_i),
      .w_en_i  (ram_w_en),
      .w_addr_i(ram_w_addr),
      .w_data_i(ram_w_data),
      .r_en_i  (ram_r_en),
      .r_addr_i(ram_r_addr),
      .r_data_o(ram_r_data)
   );

   fifo_rd_stage #(
      .DATA_W(R_DATA_W)
   ) u_rd (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .clr_i      (clr_i),
      .r_en_o     (r_en),
      .r_empty_i  (r_empty),
      .r_data_i   (r_data),
      .out_valid_o(out_valid_o),
      .out_data_o (out_data_o),
      .out_ready_i(out_ready_i)
   );

endmodule

// File: verif/fifo_props.sv
`timescale 1ns/100ps

module fifo_props #(
   parameter int R_DATA_W = 32,
   parameter int ADDR_W   = 6
) (
   input logic clk_i,
   input logic rst_n_i,
   input logic clr_i,
   input logic in_ready_o,
   input logic out_valid_o,
   input logic [R_DATA_W-1:0] out_data_o,
   input logic out_ready_i,
   input logic [ADDR_W:0] level_o
);

   int unsigned fail_cnt = 0;

   // a stalled word stays put until it is taken
   a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_o && !out_ready_i && !clr_i |=> out_valid_o && $stable(out_data_o))
   else begin
      $error("out_data_o changed or dropped while the output was stalled");
      fail_cnt++;
   end

   // first edge out of reset
   a_reset_vals: assert property (@(posedge clk_i)
      $rose(rst_n_i) |-> !out_valid_o && in_ready_o)
   else begin
      $error("out_valid_o or in_ready_o wrong right after reset release");
      fail_cnt++;
   end

   a_level_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      level_o <= (1 << ADDR_W))
   else begin
      $error("level_o above the FIFO size");
      fail_cnt++;
   end

endmodule

bind fifo_top fifo_props #(
   .R_DATA_W(R_DATA_W),
   .ADDR_W  (ADDR_W)
) u_props (
   .clk_i      (clk_i),
   .rst_n_i    (rst_n_i),
   .clr_i      (clr_i),
   .in_ready_o (in_ready_o),
   .out_valid_o(out_valid_o),
   .out_data_o (out_data_o),
   .out_ready_i(out_ready_i),
   .level_o    (level_o)
);

// File: verif/fifo_tb.sv
`timescale 1ns/100ps

module fifo_tb;

   localparam int W_W = fifo_pkg::DEF_W_DATA_W;
   localparam int R_W = fifo_pkg::DEF_R_DATA_W;
   localparam int A_W = fifo_pkg::DEF_ADDR_W;
   localparam int RATIO = R_W / W_W;
   localparam int FULL_BYTES = 2 ** A_W + fifo_pkg::RD_SLOTS * RATIO;
   localparam int MAX_CYCLES = 20000;
   localparam logic [15:0] READY_PAT = 16'b1011_0010_0111_0100;

   logic clk_i;
   logic rst_n_i;
   logic clr_i;
   logic in_valid_i;
   logic [W_W-1:0] in_data_i;
   logic in_ready_o;
   logic out_valid_o;
   logic [R_W-1:0] out_data_o;
   logic out_ready_i;
   logic [A_W:0] level_o;

   logic [W_W-1:0] part_q[$];
   logic [R_W-1:0] exp_q[$];
   int bytes_in = 0;
   int words_out = 0;
   int n_pass = 0;
   int n_fail = 0;
   int cycles = 0;

   fifo_top dut (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .clr_i      (clr_i),
      .in_valid_i (in_valid_i),
      .in_data_i  (in_data_i),
      .in_ready_o (in_ready_o),
      .out_valid_o(out_valid_o),
      .out_data_o (out_data_o),
      .out_ready_i(out_ready_i),
      .level_o    (level_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
         $display("Testbench failed");
         $finish;
      end
   end

   task automatic check_word(input string name, input logic [R_W-1:0] exp,
                             input logic [R_W-1:0] act);
      if (act !== exp) begin
         $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
         n_fail++;
      end else begin
         n_pass++;
      end
   endtask

   task automatic check_level(input string name, input logic [A_W:0] exp,
                              input logic [A_W:0] act);
      if (act !== exp) begin
         $display("error at %0t: %s expected %0d got %0d", $time, name, exp, act);
         n_fail++;
      end else begin
         n_pass++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("error at %0t: %s expected %b got %b", $time, name, exp, act);
         n_fail++;
      end else begin
         n_pass++;
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp) begin
         $display("error at %0t: %s expected %0d got %0d", $time, name, exp, act);
         n_fail++;
      end else begin
         n_pass++;
      end
   endtask

   // reference model, handshakes seen mid-cycle take effect at the next edge
   always @(negedge clk_i) begin : ref_model
      logic [R_W-1:0] w;
      if (rst_n_i && !clr_i) begin
         if (in_valid_i && in_ready_o) begin
            part_q.push_back(in_data_i);
            bytes_in++;
            if (part_q.size() == RATIO) begin
               // first byte into the low lane
               for (int i = 0; i < RATIO; i++) begin
                  w[i*W_W +: W_W] = part_q[i];
               end
               part_q.delete();
               exp_q.push_back(w);
            end
         end
         if (out_valid_o && out_ready_i) begin
            if (exp_q.size() == 0) begin
               $display("output delivered a word while none was expected");
               n_fail++;
            end else begin
               check_word("out_data_o", exp_q.pop_front(), out_data_o);
            end
            words_out++;
         end
      end
   end

   task automatic report_test(input string name, input int fails_before);
      $display("test %s finished with %0d errors", name, n_fail - fails_before);
   endtask

   // called 1 ns after an edge, returns 1 ns after the accepting edge
   task automatic send_byte(input logic [W_W-1:0] b);
      in_valid_i = 1'b1;
      in_data_i = b;
      @(negedge clk_i);
      while (!in_ready_o) @(negedge clk_i);
      @(posedge clk_i);
      #1;
      in_valid_i = 1'b0;
   endtask

   task automatic drain_words();
      out_ready_i = 1'b1;
      while (exp_q.size() != 0) @(posedge clk_i);
      @(posedge clk_i);
      #1;
      @(negedge clk_i);
      check_bit("out_valid_o", 1'b0, out_valid_o);
      @(posedge clk_i);
      #1;
   endtask

   task automatic reset_test();
      int f0;
      f0 = n_fail;
      @(negedge clk_i);
      check_bit("in_ready_o", 1'b1, in_ready_o);
      check_bit("out_valid_o", 1'b0, out_valid_o);
      check_level("level_o", '0, level_o);
      @(posedge clk_i);
      #1;
      report_test("reset", f0);
   endtask

   task automatic packing_test();
      int f0;
      logic [R_W-1:0] w;
      f0 = n_fail;
      out_ready_i = 1'b1;
      for (int i = 0; i < RATIO; i++) begin
         w[i*W_W +: W_W] = W_W'($urandom);
         send_byte(w[i*W_W +: W_W]);
      end
      // two edges from the last byte to a valid word
      @(negedge clk_i);
      check_bit("out_valid_o", 1'b0, out_valid_o);
      @(negedge clk_i);
      check_bit("out_valid_o", 1'b0, out_valid_o);
      @(negedge clk_i);
      check_bit("out_valid_o", 1'b1, out_valid_o);
      check_word("out_data_o", w, out_data_o);
      @(posedge clk_i);
      #1;
      drain_words();
      report_test("packing", f0);
   endtask

   task automatic full_test();
      int f0;
      int start;
      int idle;
      f0 = n_fail;
      start = bytes_in;
      idle = 0;
      out_ready_i = 1'b0;
      in_valid_i = 1'b1;
      while (idle < 4) begin
         in_data_i = W_W'($urandom);
         @(negedge clk_i);
         idle = in_ready_o ? 0 : idle + 1;
         @(posedge clk_i);
         #1;
      end
      in_valid_i = 1'b0;
      check_count("accepted bytes", FULL_BYTES, bytes_in - start);
      @(negedge clk_i);
      check_level("level_o", (A_W + 1)'(2 ** A_W), level_o);
      check_bit("in_ready_o", 1'b0, in_ready_o);
      check_bit("out_valid_o", 1'b1, out_valid_o);
      @(posedge clk_i);
      #1;
      drain_words();
      report_test("full", f0);
   endtask

   task automatic backpressure_test();
      int f0;
      int w0;
      int sent;
      int cyc;
      f0 = n_fail;
      w0 = words_out;
      sent = 0;
      cyc = 0;
      in_valid_i = 1'b1;
      while (sent < 12 * RATIO) begin
         in_data_i = W_W'($urandom);
         out_ready_i = READY_PAT[cyc % 16];
         @(negedge clk_i);
         if (in_ready_o) sent++;
         @(posedge clk_i);
         #1;
         cyc++;
      end
      in_valid_i = 1'b0;
      drain_words();
      check_count("words out", 12, words_out - w0);
      report_test("backpressure", f0);
   endtask

   task automatic random_test();
      int f0;
      int pend;
      int held;
      f0 = n_fail;
      for (int c = 0; c < 500; c++) begin
         in_valid_i = 1'($urandom % 2);
         in_data_i = W_W'($urandom);
         out_ready_i = (($urandom % 4) != 0);
         @(posedge clk_i);
         #1;
      end
      in_valid_i = 1'b0;
      out_ready_i = 1'b0;
      repeat (6) @(posedge clk_i);
      #1;
      // stalled output, read stage holds at most two whole words
      for (int k = 0; k < 8; k++) begin
         if (in_ready_o) send_byte(W_W'($urandom));
         repeat (6) @(posedge clk_i);
         #1;
         pend = bytes_in - RATIO * words_out;
         held = (pend / RATIO < fifo_pkg::RD_SLOTS) ? pend / RATIO : fifo_pkg::RD_SLOTS;
         @(negedge clk_i);
         check_level("level_o", (A_W + 1)'(pend - RATIO * held), level_o);
         @(posedge clk_i);
         #1;
      end
      out_ready_i = 1'b1;
      while (part_q.size() != 0) send_byte(W_W'($urandom));
      drain_words();
      report_test("random", f0);
   endtask

   task automatic clear_test();
      int f0;
      logic [R_W-1:0] w;
      f0 = n_fail;
      out_ready_i = 1'b0;
      for (int i = 0; i < 6; i++) begin
         send_byte(W_W'($urandom));
      end
      repeat (4) @(posedge clk_i);
      #1;
      clr_i = 1'b1;
      part_q.delete();
      exp_q.delete();
      @(posedge clk_i);
      #1;
      clr_i = 1'b0;
      @(negedge clk_i);
      check_level("level_o", '0, level_o);
      check_bit("out_valid_o", 1'b0, out_valid_o);
      check_bit("in_ready_o", 1'b1, in_ready_o);
      @(posedge clk_i);
      #1;
      out_ready_i = 1'b1;
      for (int i = 0; i < RATIO; i++) begin
         w[i*W_W +: W_W] = W_W'($urandom);
         send_byte(w[i*W_W +: W_W]);
      end
      @(negedge clk_i);
      while (!out_valid_o) @(negedge clk_i);
      check_word("out_data_o", w, out_data_o);
      @(posedge clk_i);
      #1;
      drain_words();
      report_test("clear", f0);
   endtask

   initial begin
      int total_fail;
      void'($urandom(32'h84897fdb));
      rst_n_i = 1'b0;
      clr_i = 1'b0;
      in_valid_i = 1'b0;
      in_data_i = '0;
      out_ready_i = 1'b0;
      repeat (5) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      reset_test();
      packing_test();
      full_test();
      backpressure_test();
      random_test();
      clear_test();
      total_fail = n_fail + int'(dut.u_props.fail_cnt);
      $display("checks passed %0d, failed %0d, assertion failures %0d",
               n_pass, n_fail, dut.u_props.fail_cnt);
      if (total_fail == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: sources.f
design/fifo_pkg.sv
design/fifo_asym_converter.sv
design/fifo_sync.sv
design/fifo_lane_ram.sv
design/fifo_rd_stage.sv
design/fifo_top.sv
verif/fifo_props.sv
verif/fifo_tb.sv
